// ==== Makefile ====
# Verilator flow for the trigger pulse generator

VERILATOR ?= verilator
FILELIST  ?= sim.f
TB_TOP    ?= trig_pulse_tb
RTL_TOP   ?= trig_pulse_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim.f ====
src/trig_pkg.sv
src/reset_sequencer.sv
src/pulse_pattern_gen.sv
src/word_serializer.sv
src/trig_pulse_top.sv
test/trig_pulse_chk.sv
test/trig_pulse_tb.sv

// ==== src/pulse_pattern_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pulse_pattern_gen #(
	parameter int WORD_WIDTH   = 8,
	parameter int PERIOD_LOG2  = 24,
	parameter int LONG_REPEATS = 8
) (
	input wire              clock,
	input wire              run_reset,
	input wire trig_pkg::mode_t  mode,
	input wire              trigger_in,
	output trig_pkg::frame_t frame,
	output logic            req,
	input wire              ack,
	output logic            sync
);

	localparam int INDEX_WIDTH = $clog2(trig_pkg::MAX_WORD_WIDTH);
	localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(WORD_WIDTH - 1);
	localparam logic [3:0] LONG_COUNT = 4'(LONG_REPEATS - 1);

	typedef enum logic [1:0] {
		idle,
		request,
		wait_release
	} state_t;

	state_t                   state;
	logic                     trig_meta;
	logic                     trig_sync;
	logic                     trig_prev;
	logic                     trig_rise;
	logic [PERIOD_LOG2-1:0]   period_cnt;
	logic                     period_wrap;
	logic [INDEX_WIDTH-1:0]   len_index;
	logic                     event_hit;
	logic                     accept;
	trig_pkg::frame_t         next_frame;

	// trigger is asynchronous, two flops then one more for the edge
	always_ff @(posedge clock) begin
		if (run_reset) begin
			trig_meta <= 1'b0;
			trig_sync <= 1'b0;
			trig_prev <= 1'b0;
		end else begin
			trig_meta <= trigger_in;
			trig_sync <= trig_meta;
			trig_prev <= trig_sync;
		end
	end

	assign trig_rise = trig_sync & ~trig_prev;

	// free running, starts from zero when run_reset falls
	always_ff @(posedge clock) begin
		if (run_reset) begin
			period_cnt <= '0;
		end else begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

	assign period_wrap = &period_cnt;

	// external edges in external mode, period wrap otherwise
	assign event_hit = (mode == trig_pkg::external) ? trig_rise : period_wrap;

	// busy transfer drops the event
	assign accept = (state == idle) && event_hit && !req && !ack;

	always_comb begin
		if (mode == trig_pkg::long_pulse) begin
			next_frame.word    = '1;
			next_frame.repeats = LONG_COUNT;
			next_frame.first   = 1'b0;
		end else begin
			next_frame.word    = trig_pkg::pulse_word(len_index);
			next_frame.repeats = 4'd0;
			next_frame.first   = (len_index == '0);
		end
	end

	// payload, held stable while req is up
	always_ff @(posedge clock) begin
		if (accept) begin
			frame <= next_frame;
		end
	end

	always_ff @(posedge clock) begin
		if (run_reset) begin
			state     <= idle;
			req       <= 1'b0;
			sync      <= 1'b0;
			len_index <= '0;
		end else begin
			case (state)
				idle: begin
					if (accept) begin
						req   <= 1'b1;
						sync  <= next_frame.first;
						state <= request;
						// long pulses leave the length cycle where it was
						if (mode != trig_pkg::long_pulse) begin
							if (len_index == LAST_INDEX) begin
								len_index <= '0;
							end else begin
								len_index <= len_index + 1'b1;
							end
						end
					end
				end
				request: begin
					if (ack) begin
						req   <= 1'b0;
						state <= wait_release;
					end
				end
				wait_release: begin
					// serializer drops ack after the last bit
					if (!ack) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/reset_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int RESET_LOG2 = 10
) (
	input wire   clock,
	input wire   reset1,
	output logic run_reset,
	output logic ready
);

	logic [RESET_LOG2:0] count;
	logic                done;

	// top bit marks the end of the hold-off
	assign done = count[RESET_LOG2];

	always_ff @(posedge clock) begin
		if (reset1) begin
			count     <= '0;
			run_reset <= 1'b1;
			ready     <= 1'b0;
		end else begin
			// stop counting once the top bit is set
			if (!done) begin
				count <= count + 1'b1;
			end
			run_reset <= ~done;
			ready     <= done;
		end
	end

endmodule

`default_nettype wire

// ==== src/trig_pkg.sv ====
`default_nettype none

package trig_pkg;

	// widest word the serializer can carry
	parameter int MAX_WORD_WIDTH = 16;

	// pulse source
	typedef enum logic [1:0] {
		self_triggered = 2'd0,
		long_pulse     = 2'd1,
		external       = 2'd2
	} mode_t;

	// one transfer from the generator to the serializer
	typedef struct packed {
		// left-aligned, only the top WORD_WIDTH bits go out
		logic [MAX_WORD_WIDTH-1:0] word;
		// times the word is sent, minus one
		logic [3:0]                repeats;
		// length index 0, start of a length cycle
		logic                      first;
	} frame_t;

	// index k gives k+1 leading ones, then zeros
	function automatic logic [MAX_WORD_WIDTH-1:0] pulse_word(
		input logic [$clog2(MAX_WORD_WIDTH)-1:0] index
	);
		logic [MAX_WORD_WIDTH-1:0] ones;
		int                        shift_by;
		ones = '1;
		shift_by = int'(index) + 1;
		return ~(ones >> shift_by);
	endfunction

endpackage

`default_nettype wire

// ==== src/trig_pulse_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_pulse_top #(
	parameter int WORD_WIDTH   = 8,
	parameter int PERIOD_LOG2  = 24,
	parameter int RESET_LOG2   = 10,
	parameter int LONG_REPEATS = 8
) (
	input wire             clock,
	input wire             reset1,
	input wire trig_pkg::mode_t mode,
	input wire             trigger_in,
	output logic           serial_out,
	output logic           sync,
	output logic           ready
);

	logic             run_reset;
	trig_pkg::frame_t frame;
	logic             req;
	logic             ack;

	// holds the generator and serializer in reset after reset1
	reset_sequencer #(
		.RESET_LOG2(RESET_LOG2)
	) sequencer (
		.clock(clock),
		.reset1(reset1),
		.run_reset(run_reset),
		.ready(ready)
	);

	pulse_pattern_gen #(
		.WORD_WIDTH(WORD_WIDTH),
		.PERIOD_LOG2(PERIOD_LOG2),
		.LONG_REPEATS(LONG_REPEATS)
	) generator (
		.clock(clock),
		.run_reset(run_reset),
		.mode(mode),
		.trigger_in(trigger_in),
		.frame(frame),
		.req(req),
		.ack(ack),
		.sync(sync)
	);

	// four-phase req/ack between generator and serializer
	word_serializer #(
		.WORD_WIDTH(WORD_WIDTH)
	) serializer (
		.clock(clock),
		.run_reset(run_reset),
		.frame(frame),
		.req(req),
		.ack(ack),
		.serial_out(serial_out)
	);

endmodule

`default_nettype wire

// ==== src/word_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_serializer #(
	parameter int WORD_WIDTH = 8
) (
	input wire              clock,
	input wire              run_reset,
	input wire trig_pkg::frame_t frame,
	input wire              req,
	output logic            ack,
	output logic            serial_out
);

	localparam int BIT_WIDTH = $clog2(WORD_WIDTH);
	localparam logic [BIT_WIDTH-1:0] LAST_BIT = BIT_WIDTH'(WORD_WIDTH - 1);

	typedef enum logic [1:0] {
		idle,
		shift,
		releasing
	} state_t;

	state_t                state;
	logic [WORD_WIDTH-1:0] word_q;
	logic [WORD_WIDTH-1:0] shift_q;
	logic [BIT_WIDTH-1:0]  bit_cnt;
	logic [3:0]            rep_cnt;
	logic                  take;
	logic                  last_bit;

	assign take     = (state == idle) && req && !ack;
	assign last_bit = (bit_cnt == LAST_BIT);

	// word kept for reloading at each repeat boundary
	always_ff @(posedge clock) begin
		if (take) begin
			word_q  <= frame.word[trig_pkg::MAX_WORD_WIDTH-1 -: WORD_WIDTH];
			shift_q <= frame.word[trig_pkg::MAX_WORD_WIDTH-1 -: WORD_WIDTH];
		end else if (state == shift) begin
			if (last_bit) begin
				shift_q <= word_q;
			end else begin
				shift_q <= shift_q << 1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (run_reset) begin
			state      <= idle;
			ack        <= 1'b0;
			serial_out <= 1'b0;
			bit_cnt    <= '0;
			rep_cnt    <= '0;
		end else begin
			case (state)
				idle: begin
					serial_out <= 1'b0;
					if (take) begin
						ack     <= 1'b1;
						bit_cnt <= '0;
						rep_cnt <= frame.repeats;
						state   <= shift;
					end
				end
				shift: begin
					// msb first
					serial_out <= shift_q[WORD_WIDTH-1];
					if (last_bit) begin
						bit_cnt <= '0;
						if (rep_cnt == 4'd0) begin
							state <= releasing;
						end else begin
							rep_cnt <= rep_cnt - 1'b1;
						end
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				releasing: begin
					serial_out <= 1'b0;
					if (!req) begin
						ack   <= 1'b0;
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== test/trig_pulse_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_pulse_chk (
	input wire clock,
	input wire run_reset,
	input wire req,
	input wire ack,
	input wire serial_out
);

	// failed assertions so far
	int fail_count = 0;

	// serializer only answers a pending request
	ack_needs_req: assert property (
		@(posedge clock) disable iff (run_reset)
		$rose(ack) |-> req
	) else begin
		$error("ack rose while req was low");
		fail_count++;
	end

	// a raised req stays up until ack
	req_holds: assert property (
		@(posedge clock) disable iff (run_reset)
		(req && !ack) |=> req
	) else begin
		$error("req dropped before ack");
		fail_count++;
	end

	// line is quiet outside a transfer
	idle_line_low: assert property (
		@(posedge clock) disable iff (run_reset)
		!ack |-> !serial_out
	) else begin
		$error("serial_out high while ack is low");
		fail_count++;
	end

endmodule

bind word_serializer trig_pulse_chk serializer_chk (
	.clock(clock),
	.run_reset(run_reset),
	.req(req),
	.ack(ack),
	.serial_out(serial_out)
);

`default_nettype wire

// ==== test/trig_pulse_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_pulse_tb;

	localparam int WORD_WIDTH   = 8;
	localparam int PERIOD_LOG2  = 7;
	localparam int RESET_LOG2   = 4;
	localparam int LONG_REPEATS = 4;

	localparam int PERIOD       = 1 << PERIOD_LOG2;
	localparam int EXT_TRIGGERS = 10;
	localparam int TRIG_HOLD    = 4;
	localparam int HELD_CYCLES  = 60;
	localparam int SETTLE       = 30;
	localparam int LONG_FRAMES  = 2;
	localparam int LONG_RUN     = WORD_WIDTH * LONG_REPEATS;

	// per-test cycle budgets add up to the watchdog limit
	localparam int RESET_BUDGET = 8 + (1 << RESET_LOG2);
	localparam int SELF_BUDGET  = (2 * WORD_WIDTH + 1) * PERIOD;
	localparam int EXT_BUDGET   = EXT_TRIGGERS * (TRIG_HOLD + 42) + HELD_CYCLES + 2 * SETTLE;
	localparam int DROP_BUDGET  = 3 * SETTLE + 16;
	localparam int LONG_BUDGET  = (LONG_FRAMES + 1) * PERIOD + 2 * SETTLE + 8;
	localparam int TIMEOUT_CYCLES = RESET_BUDGET + SELF_BUDGET + EXT_BUDGET
		+ DROP_BUDGET + LONG_BUDGET + 200;

	logic            clock;
	logic            reset1;
	trig_pkg::mode_t mode;
	logic            trigger_in;
	logic            serial_out;
	logic            sync;
	logic            ready;

	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	int          exp_index = 0;
	logic [31:0] lcg_state = 32'd68822;

	// high runs seen on serial_out and sync at their first bit
	int   run_len_q[$];
	logic run_sync_q[$];

	trig_pulse_top #(
		.WORD_WIDTH(WORD_WIDTH),
		.PERIOD_LOG2(PERIOD_LOG2),
		.RESET_LOG2(RESET_LOG2),
		.LONG_REPEATS(LONG_REPEATS)
	) DUT (
		.clock(clock),
		.reset1(reset1),
		.mode(mode),
		.trigger_in(trigger_in),
		.serial_out(serial_out),
		.sync(sync),
		.ready(ready)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// pulse-width monitor sampling on the falling edge
	initial begin
		int   run_len;
		logic run_sync;
		run_len = 0;
		run_sync = 1'b0;
		forever begin
			@(negedge clock);
			if (serial_out === 1'b1) begin
				if (run_len == 0) begin
					run_sync = sync;
				end
				run_len = run_len + 1;
			end else if (run_len != 0) begin
				run_len_q.push_back(run_len);
				run_sync_q.push_back(run_sync);
				run_len = 0;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
			$display("checks: %0d, errors: %0d", check_count, error_count + 1);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			$display("** Error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			error_count++;
		end
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// index k gives a run of k+1 ones
	function automatic int next_length();
		int len;
		len = exp_index + 1;
		exp_index = (exp_index + 1) % WORD_WIDTH;
		return len;
	endfunction

	task automatic wait_runs(input int count, input int limit, input string label);
		int waited;
		waited = 0;
		while (run_len_q.size() < count && waited < limit) begin
			@(posedge clock);
			waited++;
		end
		if (run_len_q.size() < count) begin
			$display("%s: only %0d of %0d pulses came out in %0d cycles", label,
				run_len_q.size(), count, waited);
			error_count++;
		end
	endtask

	task automatic expect_run(input int exp_len);
		int   len;
		logic at_sync;
		if (run_len_q.size() == 0) begin
			$display("no pulse on serial_out where one of length %0d was due", exp_len);
			error_count++;
		end else begin
			len = run_len_q.pop_front();
			at_sync = run_sync_q.pop_front();
			compare_value("serial_out run length", 32'(len), 32'(exp_len));
			compare_value("sync", 32'(at_sync), 32'(exp_len == 1));
		end
	endtask

	task automatic pulse_trigger(input int hold);
		@(posedge clock);
		trigger_in <= 1'b1;
		repeat (hold) @(posedge clock);
		trigger_in <= 1'b0;
	endtask

	task automatic reset_release_test();
		int waited;
		repeat (4) @(posedge clock);
		@(negedge clock);
		compare_value("ready", 32'(ready), 32'd0);
		compare_value("serial_out", 32'(serial_out), 32'd0);
		compare_value("sync", 32'(sync), 32'd0);
		@(posedge clock);
		reset1 <= 1'b0;
		// first edge that sees reset1 low
		@(posedge clock);
		waited = 0;
		do begin
			@(posedge clock);
			waited++;
			@(negedge clock);
			compare_value("serial_out", 32'(serial_out), 32'd0);
			compare_value("sync", 32'(sync), 32'd0);
		end while (!ready && waited < RESET_BUDGET);
		compare_value("ready delay", 32'(waited), 32'(1 << RESET_LOG2));
	endtask

	task automatic self_cycle_test();
		@(posedge clock);
		mode <= trig_pkg::self_triggered;
		wait_runs(2 * WORD_WIDTH, SELF_BUDGET, "self-triggered mode");
		for (int i = 0; i < 2 * WORD_WIDTH; i++) begin
			expect_run(next_length());
		end
	endtask

	task automatic external_trigger_test();
		int gap;
		@(posedge clock);
		mode <= trig_pkg::external;
		for (int i = 0; i < EXT_TRIGGERS; i++) begin
			gap = 20 + int'(next_rand() >> 16) % 21;
			pulse_trigger(TRIG_HOLD);
			repeat (gap) @(posedge clock);
		end
		// a level held high is still one edge
		pulse_trigger(HELD_CYCLES);
		repeat (SETTLE) @(posedge clock);
		wait_runs(EXT_TRIGGERS + 1, SETTLE, "external mode");
		compare_value("pulse count", 32'(run_len_q.size()), 32'(EXT_TRIGGERS + 1));
		for (int i = 0; i < EXT_TRIGGERS + 1; i++) begin
			expect_run(next_length());
		end
	endtask

	task automatic dropped_trigger_test();
		@(posedge clock);
		trigger_in <= 1'b1;
		@(posedge clock);
		trigger_in <= 1'b0;
		repeat (2) @(posedge clock);
		// second edge lands while the first frame is busy
		trigger_in <= 1'b1;
		repeat (2) @(posedge clock);
		trigger_in <= 1'b0;
		repeat (SETTLE) @(posedge clock);
		pulse_trigger(TRIG_HOLD);
		repeat (SETTLE) @(posedge clock);
		wait_runs(2, SETTLE, "dropped trigger");
		compare_value("pulse count", 32'(run_len_q.size()), 32'd2);
		expect_run(next_length());
		expect_run(next_length());
	endtask

	task automatic long_pulse_test();
		@(posedge clock);
		mode <= trig_pkg::long_pulse;
		wait_runs(LONG_FRAMES, (LONG_FRAMES + 1) * PERIOD, "long mode");
		@(posedge clock);
		mode <= trig_pkg::external;
		pulse_trigger(TRIG_HOLD);
		repeat (SETTLE) @(posedge clock);
		wait_runs(LONG_FRAMES + 1, SETTLE, "external after long mode");
		compare_value("pulse count", 32'(run_len_q.size()), 32'(LONG_FRAMES + 1));
		for (int i = 0; i < LONG_FRAMES; i++) begin
			expect_run(LONG_RUN);
		end
		// length cycle picks up where it stopped
		expect_run(next_length());
	endtask

	initial begin
		reset1 = 1'b1;
		mode = trig_pkg::self_triggered;
		trigger_in = 1'b0;
		reset_release_test();
		self_cycle_test();
		external_trigger_test();
		dropped_trigger_test();
		long_pulse_test();
		repeat (4) @(posedge clock);
		error_count += DUT.serializer.serializer_chk.fail_count;
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
